//--- Makefile
# Verilator simulation of the Wishbone to HyperBus front end

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless the log shows a pass"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -j 0 --top-module tb_hyperbus_wb -f hyperbus_wb.f -o sim
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hyper_chip_decode.sv
// Chip select decoder for the HyperBus front end.
// Scans the range table in order and returns the matching chip as one-hot.
// Falls back to chip 0 when no range holds the address. Purely combinational.

`default_nettype none

module hyper_chip_decode (
    input  logic [hyper_pkg::HypAddrWidth-1:0]               addr_i,
    input  hyper_pkg::chip_rule_t [hyper_pkg::NumChips-1:0] rules_i,
    output logic [hyper_pkg::NumChips-1:0]                   cs_o
);

    logic [hyper_pkg::ChipIdxWidth-1:0] sel_idx;
    logic                               hit;

    // first matching rule wins
    always_comb begin : proc_match
        sel_idx = '0;
        hit     = 1'b0;
        for (int unsigned i = 0; i < hyper_pkg::NumChips; i++) begin
            if (!hit &&
                (addr_i >= rules_i[i].start_addr) &&
                (addr_i <  rules_i[i].end_addr)) begin
                sel_idx = rules_i[i].idx;
                hit     = 1'b1;
            end
        end
    end

    // index to one-hot, default index is already 0
    always_comb begin : proc_onehot
        cs_o          = '0;
        cs_o[sel_idx] = 1'b1;
    end

endmodule

`default_nettype wire

//--- hyper_pkg.sv
// Shared types and constants for the Wishbone to HyperBus front end.
// Holds the PHY stream payloads, the chip range rule and the adapter states.
// Every other file refers to these by scoped name.

`default_nettype none

package hyper_pkg;

    // number of HyperBus chips behind the PHY
    localparam int unsigned NumChips     = 2;
    localparam int unsigned ChipIdxWidth = (NumChips > 1) ? $clog2(NumChips) : 1;

    // Wishbone side
    localparam int unsigned WbAddrWidth = 32;
    localparam int unsigned WbDataWidth = 32;
    localparam int unsigned WbSelWidth  = WbDataWidth / 8;

    // HyperBus side, word addressed
    localparam int unsigned HypAddrWidth = 31;
    localparam int unsigned HypDataWidth = 16;
    localparam int unsigned HypStrbWidth = HypDataWidth / 8;

    // two beats per access, encoded as count minus one
    localparam logic [7:0] BurstLen = 8'd1;

    // transaction descriptor toward the PHY
    typedef struct packed {
        logic [HypAddrWidth-1:0] address;
        logic [7:0]              burst;
        logic                    burst_type;
        logic                    address_space;
        logic                    write;
    } hyper_tf_t;

    // one write beat
    typedef struct packed {
        logic [HypDataWidth-1:0] data;
        logic [HypStrbWidth-1:0] strb;
    } hyper_tx_t;

    // one read beat
    typedef struct packed {
        logic [HypDataWidth-1:0] data;
        logic                    last;
        logic                    error;
    } hyper_rx_t;

    // write response
    typedef struct packed {
        logic last;
        logic error;
    } hyper_b_t;

    // address range of one chip, end is exclusive
    typedef struct packed {
        logic [ChipIdxWidth-1:0] idx;
        logic [HypAddrWidth-1:0] start_addr;
        logic [HypAddrWidth-1:0] end_addr;
    } chip_rule_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WDATA,
        ST_WRESP,
        ST_RDATA,
        ST_DONE
    } adapter_state_e;

endpackage

`default_nettype wire

//--- hyper_wb_adapter.sv
// Wishbone classic slave that turns one 32-bit access into a HyperBus transfer.
// Issues a two-beat descriptor, splits writes and merges reads as 16-bit beats,
// and ends each access with ack_o, or err_o if the PHY flagged an error.

`default_nettype none

module hyper_wb_adapter (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    // Wishbone classic slave
    input  logic                                  cyc_i,
    input  logic                                  stb_i,
    input  logic                                  we_i,
    input  logic [hyper_pkg::WbAddrWidth-1:0]     adr_i,
    input  logic [hyper_pkg::WbSelWidth-1:0]      sel_i,
    input  logic [hyper_pkg::WbDataWidth-1:0]     dat_i,
    output logic [hyper_pkg::WbDataWidth-1:0]     dat_o,
    output logic                                  ack_o,
    output logic                                  err_o,
    // chip select from the decoder
    input  logic [hyper_pkg::NumChips-1:0]        cs_i,
    output logic [hyper_pkg::NumChips-1:0]        trans_cs_o,
    // PHY streams
    output hyper_pkg::hyper_tf_t                  trans_o,
    output logic                                  trans_valid_o,
    input  logic                                  trans_ready_i,
    output hyper_pkg::hyper_tx_t                  tx_o,
    output logic                                  tx_valid_o,
    input  logic                                  tx_ready_i,
    input  hyper_pkg::hyper_rx_t                  rx_i,
    input  logic                                  rx_valid_i,
    output logic                                  rx_ready_o,
    input  hyper_pkg::hyper_b_t                   b_i,
    input  logic                                  b_valid_i,
    output logic                                  b_ready_o
);

    hyper_pkg::adapter_state_e state_q, state_d;

    // beat index within the two-beat burst, high on the upper half
    logic beat_q, beat_d;
    // sticky error for the access in flight
    logic err_q, err_d;

    logic access_start;
    logic rx_fire;

    // latched access, held stable for the whole transfer
    hyper_pkg::hyper_tf_t                 tf_q;
    logic [hyper_pkg::NumChips-1:0]       cs_q;
    logic [hyper_pkg::WbDataWidth-1:0]    wdata_q;
    logic [hyper_pkg::WbSelWidth-1:0]     sel_q;
    logic [hyper_pkg::WbDataWidth-1:0]    rdata_q;

    assign access_start = (state_q == hyper_pkg::ST_IDLE) && cyc_i && stb_i;
    assign rx_fire      = rx_valid_i && rx_ready_o;

    always_comb begin : proc_next_state
        state_d = state_q;
        beat_d  = beat_q;
        err_d   = err_q;
        case (state_q)
            hyper_pkg::ST_IDLE: begin
                if (access_start) begin
                    state_d = hyper_pkg::ST_ISSUE;
                    beat_d  = 1'b0;
                    err_d   = 1'b0;
                end
            end
            hyper_pkg::ST_ISSUE: begin
                if (trans_ready_i) begin
                    state_d = tf_q.write ? hyper_pkg::ST_WDATA : hyper_pkg::ST_RDATA;
                end
            end
            hyper_pkg::ST_WDATA: begin
                if (tx_ready_i) begin
                    if (beat_q) begin
                        state_d = hyper_pkg::ST_WRESP;
                        beat_d  = 1'b0;
                    end else begin
                        beat_d = 1'b1;
                    end
                end
            end
            hyper_pkg::ST_WRESP: begin
                if (b_valid_i) begin
                    err_d = err_q | b_i.error;
                    // only the final response closes the write
                    if (b_i.last) begin
                        state_d = hyper_pkg::ST_DONE;
                    end
                end
            end
            hyper_pkg::ST_RDATA: begin
                if (rx_valid_i) begin
                    err_d = err_q | rx_i.error;
                    if (beat_q) begin
                        state_d = hyper_pkg::ST_DONE;
                        beat_d  = 1'b0;
                    end else begin
                        beat_d = 1'b1;
                    end
                end
            end
            hyper_pkg::ST_DONE: begin
                // ack or err is out this cycle, the master moves on
                state_d = hyper_pkg::ST_IDLE;
            end
            default: begin
                state_d = hyper_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_ctrl_regs
        if (!arst_n_i) begin
            state_q <= hyper_pkg::ST_IDLE;
            beat_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
            err_q   <= err_d;
        end
    end

    always_ff @(posedge clk_i) begin : proc_payload_regs
        if (access_start) begin
            tf_q.address       <= adr_i[hyper_pkg::HypAddrWidth:1];
            tf_q.burst         <= hyper_pkg::BurstLen;
            tf_q.burst_type    <= 1'b1;
            tf_q.address_space <= adr_i[hyper_pkg::WbAddrWidth-1];
            tf_q.write         <= we_i;
            cs_q               <= cs_i;
            wdata_q            <= dat_i;
            sel_q              <= sel_i;
        end
        // lower half arrives first
        if (rx_fire) begin
            if (beat_q) begin
                rdata_q[hyper_pkg::WbDataWidth-1:hyper_pkg::HypDataWidth] <= rx_i.data;
            end else begin
                rdata_q[hyper_pkg::HypDataWidth-1:0] <= rx_i.data;
            end
        end
    end

    // write beat, lower half first
    always_comb begin : proc_tx_beat
        if (beat_q) begin
            tx_o.data = wdata_q[hyper_pkg::WbDataWidth-1:hyper_pkg::HypDataWidth];
            tx_o.strb = sel_q[hyper_pkg::WbSelWidth-1:hyper_pkg::HypStrbWidth];
        end else begin
            tx_o.data = wdata_q[hyper_pkg::HypDataWidth-1:0];
            tx_o.strb = sel_q[hyper_pkg::HypStrbWidth-1:0];
        end
    end

    assign trans_o       = tf_q;
    assign trans_cs_o    = cs_q;
    assign trans_valid_o = (state_q == hyper_pkg::ST_ISSUE);
    assign tx_valid_o    = (state_q == hyper_pkg::ST_WDATA);
    assign rx_ready_o    = (state_q == hyper_pkg::ST_RDATA);
    assign b_ready_o     = (state_q == hyper_pkg::ST_WRESP);

    // read data is returned even when the access ends in err_o
    assign dat_o = rdata_q;
    assign ack_o = (state_q == hyper_pkg::ST_DONE) && !err_q;
    assign err_o = (state_q == hyper_pkg::ST_DONE) &&  err_q;

endmodule

`default_nettype wire

//--- hyperbus_wb.f
hyper_pkg.sv
hyper_chip_decode.sv
hyper_wb_adapter.sv
hyperbus_wb.sv
tb_hyper_phy_mem.sv
tb_hyperbus_wb.sv

//--- hyperbus_wb.sv
// Top level of the Wishbone to HyperBus front end.
// Joins the access adapter and the chip decoder between a Wishbone classic
// slave port and the valid/ready streams toward a HyperBus PHY.

`default_nettype none

module hyperbus_wb (
    input  logic                                            clk_i,
    input  logic                                            arst_n_i,
    // Wishbone classic slave
    input  logic                                            cyc_i,
    input  logic                                            stb_i,
    input  logic                                            we_i,
    input  logic [hyper_pkg::WbAddrWidth-1:0]               adr_i,
    input  logic [hyper_pkg::WbSelWidth-1:0]                sel_i,
    input  logic [hyper_pkg::WbDataWidth-1:0]               dat_i,
    output logic [hyper_pkg::WbDataWidth-1:0]               dat_o,
    output logic                                            ack_o,
    output logic                                            err_o,
    // PHY streams
    output hyper_pkg::hyper_tf_t                            trans_o,
    output logic [hyper_pkg::NumChips-1:0]                  trans_cs_o,
    output logic                                            trans_valid_o,
    input  logic                                            trans_ready_i,
    output hyper_pkg::hyper_tx_t                            tx_o,
    output logic                                            tx_valid_o,
    input  logic                                            tx_ready_i,
    input  hyper_pkg::hyper_rx_t                            rx_i,
    input  logic                                            rx_valid_i,
    output logic                                            rx_ready_o,
    input  hyper_pkg::hyper_b_t                             b_i,
    input  logic                                            b_valid_i,
    output logic                                            b_ready_o,
    // chip address ranges, in word addresses
    input  hyper_pkg::chip_rule_t [hyper_pkg::NumChips-1:0] chip_rules_i
);

    logic [hyper_pkg::NumChips-1:0] chip_cs;

    // decoded straight from the port, latched by the adapter in idle
    hyper_chip_decode i_hyper_chip_decode (
        .addr_i ( adr_i[hyper_pkg::HypAddrWidth:1] ),
        .rules_i( chip_rules_i                     ),
        .cs_o   ( chip_cs                          )
    );

    hyper_wb_adapter i_hyper_wb_adapter (
        .clk_i        ( clk_i         ),
        .arst_n_i     ( arst_n_i      ),
        .cyc_i        ( cyc_i         ),
        .stb_i        ( stb_i         ),
        .we_i         ( we_i          ),
        .adr_i        ( adr_i         ),
        .sel_i        ( sel_i         ),
        .dat_i        ( dat_i         ),
        .dat_o        ( dat_o         ),
        .ack_o        ( ack_o         ),
        .err_o        ( err_o         ),
        .cs_i         ( chip_cs       ),
        .trans_cs_o   ( trans_cs_o    ),
        .trans_o      ( trans_o       ),
        .trans_valid_o( trans_valid_o ),
        .trans_ready_i( trans_ready_i ),
        .tx_o         ( tx_o          ),
        .tx_valid_o   ( tx_valid_o    ),
        .tx_ready_i   ( tx_ready_i    ),
        .rx_i         ( rx_i          ),
        .rx_valid_i   ( rx_valid_i    ),
        .rx_ready_o   ( rx_ready_o    ),
        .b_i          ( b_i           ),
        .b_valid_i    ( b_valid_i     ),
        .b_ready_o    ( b_ready_o     )
    );

endmodule

`default_nettype wire

//--- tb_hyper_phy_mem.sv
// Behavioral HyperBus PHY with a 256-entry 16-bit memory for the testbench.
// Records the last descriptor and chip select, stalls from an LCG and can flag errors.

`default_nettype none

module tb_hyper_phy_mem (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           stall_en_i,
    input  logic                           err_rx_i,
    input  logic                           err_b_i,
    input  hyper_pkg::hyper_tf_t           trans_i,
    input  logic [hyper_pkg::NumChips-1:0] trans_cs_i,
    input  logic                           trans_valid_i,
    output logic                           trans_ready_o,
    input  hyper_pkg::hyper_tx_t           tx_i,
    input  logic                           tx_valid_i,
    output logic                           tx_ready_o,
    output hyper_pkg::hyper_rx_t           rx_o,
    output logic                           rx_valid_o,
    input  logic                           rx_ready_i,
    output hyper_pkg::hyper_b_t            b_o,
    output logic                           b_valid_o,
    input  logic                           b_ready_i,
    output hyper_pkg::hyper_tf_t           last_tf_o,
    output logic [hyper_pkg::NumChips-1:0] last_cs_o
);

    logic [15:0] mem [0:255];
    logic [31:0] lcg_q;
    logic [1:0]  st_q;
    logic        beat_q;
    logic        go;
    logic [7:0]  idx;

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // fill depends on every address bit
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 16'(i * 16'h1357) ^ 16'ha5c3;
        end
    end

    assign go  = !stall_en_i || (lcg_q[7:6] != 2'b00);
    assign idx = last_tf_o.address[7:0] + {7'd0, beat_q};

    always @(posedge clk_i) begin
        if (st_q == 2'd1 && tx_valid_i && tx_ready_o) begin
            if (tx_i.strb[0]) mem[idx][7:0]  <= tx_i.data[7:0];
            if (tx_i.strb[1]) mem[idx][15:8] <= tx_i.data[15:8];
        end
    end

    // st 0 descriptor, 1 write beats, 2 write response, 3 read beats
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lcg_q <= 32'hfa62fd69;
            st_q <= 2'd0;
            beat_q <= 1'b0;
            trans_ready_o <= 1'b0;
            tx_ready_o <= 1'b0;
            rx_valid_o <= 1'b0;
            b_valid_o <= 1'b0;
            rx_o <= '0;
            b_o <= '0;
            last_tf_o <= '0;
            last_cs_o <= '0;
        end else begin
            lcg_q <= lcg_step(lcg_q);
            case (st_q)
                2'd0: begin
                    trans_ready_o <= go;
                    if (trans_valid_i && trans_ready_o) begin
                        last_tf_o <= trans_i;
                        last_cs_o <= trans_cs_i;
                        beat_q <= 1'b0;
                        trans_ready_o <= 1'b0;
                        st_q <= trans_i.write ? 2'd1 : 2'd3;
                    end
                end
                2'd1: begin
                    tx_ready_o <= go;
                    if (tx_valid_i && tx_ready_o) begin
                        beat_q <= !beat_q;
                        if (beat_q) begin
                            tx_ready_o <= 1'b0;
                            st_q <= 2'd2;
                        end
                    end
                end
                2'd2: begin
                    if (!b_valid_o) begin
                        if (go) begin
                            b_valid_o <= 1'b1;
                            b_o.last <= 1'b1;
                            b_o.error <= err_b_i;
                        end
                    end else if (b_ready_i) begin
                        b_valid_o <= 1'b0;
                        st_q <= 2'd0;
                    end
                end
                default: begin
                    if (!rx_valid_o) begin
                        if (go) begin
                            rx_valid_o <= 1'b1;
                            rx_o.data <= mem[idx];
                            rx_o.last <= beat_q;
                            // error on the first beat only, the adapter keeps it
                            rx_o.error <= err_rx_i && !beat_q;
                        end
                    end else if (rx_ready_i) begin
                        rx_valid_o <= 1'b0;
                        beat_q <= !beat_q;
                        if (beat_q) st_q <= 2'd0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb_hyperbus_wb.sv
// Directed testbench for the Wishbone to HyperBus front end.
// Drives Wishbone accesses against a behavioral PHY and checks data, descriptors,
// chip selects, error endings and operation under back-pressure.

`default_nettype none

module tb_hyperbus_wb;

    logic clk = 1'b0;
    logic arst_n;
    logic cyc, stb, we;
    logic [31:0] adr, wdat, rdat;
    logic [3:0] sel;
    logic ack, err;
    logic stall_en, err_rx, err_b;
    hyper_pkg::hyper_tf_t trans, last_tf;
    hyper_pkg::hyper_tx_t tx;
    hyper_pkg::hyper_rx_t rx;
    hyper_pkg::hyper_b_t b;
    logic [hyper_pkg::NumChips-1:0] trans_cs, last_cs;
    logic trans_valid, trans_ready, tx_valid, tx_ready;
    logic rx_valid, rx_ready, b_valid, b_ready;
    hyper_pkg::chip_rule_t [hyper_pkg::NumChips-1:0] rules;
    int checks = 0;
    int errors = 0;
    logic [31:0] rnd = 32'hfa62fd69;
    logic [31:0] ref_mem [0:15];

    always #20 clk = !clk;

    hyperbus_wb i_hyperbus_wb (
        .clk_i(clk), .arst_n_i(arst_n), .cyc_i(cyc), .stb_i(stb), .we_i(we),
        .adr_i(adr), .sel_i(sel), .dat_i(wdat), .dat_o(rdat), .ack_o(ack),
        .err_o(err), .trans_o(trans), .trans_cs_o(trans_cs),
        .trans_valid_o(trans_valid), .trans_ready_i(trans_ready), .tx_o(tx),
        .tx_valid_o(tx_valid), .tx_ready_i(tx_ready), .rx_i(rx), .rx_valid_i(rx_valid),
        .rx_ready_o(rx_ready), .b_i(b), .b_valid_i(b_valid), .b_ready_o(b_ready),
        .chip_rules_i(rules)
    );

    tb_hyper_phy_mem i_phy (
        .clk_i(clk), .arst_n_i(arst_n), .stall_en_i(stall_en), .err_rx_i(err_rx),
        .err_b_i(err_b), .trans_i(trans), .trans_cs_i(trans_cs),
        .trans_valid_i(trans_valid), .trans_ready_o(trans_ready), .tx_i(tx),
        .tx_valid_i(tx_valid), .tx_ready_o(tx_ready), .rx_o(rx), .rx_valid_o(rx_valid),
        .rx_ready_i(rx_ready), .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .last_tf_o(last_tf), .last_cs_o(last_cs)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_tf(input string name, input hyper_pkg::hyper_tf_t exp,
                            input hyper_pkg::hyper_tf_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s expected %p got %p", $time, name, exp, act);
        end
    endtask

    task automatic check_cs(input string name, input logic [hyper_pkg::NumChips-1:0] exp,
                            input logic [hyper_pkg::NumChips-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // one classic access, held until ack or err
    task automatic wb_access(input logic w, input logic [31:0] a, input logic [3:0] s,
                             input logic [31:0] d, input logic exp_err,
                             output logic [31:0] data);
        int cycles;
        logic done;
        logic seen_ack;
        logic seen_err;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= w;
        adr <= a;
        sel <= s;
        wdat <= d;
        cycles = 0;
        done = 1'b0;
        seen_ack = 1'b0;
        seen_err = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (ack || err) begin
                done = 1'b1;
                seen_ack = ack;
                seen_err = err;
                data = rdat;
            end else if (cycles > 300) begin
                $display("timeout: access to %h never ended with ack or err", a);
                $display("CHECKS FAILED");
                $finish;
            end
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        check_flag("ack_o", !exp_err, seen_ack);
        check_flag("err_o", exp_err, seen_err);
    endtask

    task automatic wb_write(input logic [31:0] a, input logic [3:0] s, input logic [31:0] d);
        logic [31:0] unused;
        wb_access(1'b1, a, s, d, 1'b0, unused);
    endtask

    task automatic wb_read(input logic [31:0] a, output logic [31:0] d);
        wb_access(1'b0, a, 4'h0, 32'h0, 1'b0, d);
    endtask

    function automatic hyper_pkg::hyper_tf_t expected_tf(input logic [31:0] a, input logic w);
        hyper_pkg::hyper_tf_t tf;
        tf.address = a[31:1];
        tf.burst = 8'd1;
        tf.burst_type = 1'b1;
        tf.address_space = a[31];
        tf.write = w;
        return tf;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    task automatic report(input string name, input int errs_before);
        $display("%-14s %s", name, (errors == errs_before) ? "ok" : "with errors");
    endtask

    // all handshake outputs quiet while idle out of reset
    task automatic test_reset_state();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_flag("trans_valid_o", 1'b0, trans_valid);
        check_flag("tx_valid_o", 1'b0, tx_valid);
        check_flag("rx_ready_o", 1'b0, rx_ready);
        check_flag("b_ready_o", 1'b0, b_ready);
        check_flag("ack_o", 1'b0, ack);
        check_flag("err_o", 1'b0, err);
        report("reset_state", e0);
    endtask

    task automatic test_write_read();
        int e0;
        logic [31:0] d;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            wb_write(32'h0000_0040 + 32'(i * 12), 4'hf, 32'hc0de_0000 + 32'(i * 32'h1111));
        end
        for (int i = 0; i < 4; i++) begin
            wb_read(32'h0000_0040 + 32'(i * 12), d);
            check_word("dat_o", 32'hc0de_0000 + 32'(i * 32'h1111), d);
        end
        report("write_read", e0);
    endtask

    task automatic test_byte_lanes();
        int e0;
        logic [31:0] exp;
        logic [31:0] d;
        logic [31:0] wd;
        e0 = errors;
        exp = 32'h1122_3344;
        wb_write(32'h0000_0300, 4'hf, exp);
        for (int s = 1; s < 16; s++) begin
            wd = 32'ha0b0_c0d0 ^ 32'(s * 32'h0101_0101);
            wb_write(32'h0000_0300, 4'(s), wd);
            exp = (exp & ~lane_mask(4'(s))) | (wd & lane_mask(4'(s)));
            wb_read(32'h0000_0300, d);
            check_word("dat_o", exp, d);
        end
        report("byte_lanes", e0);
    endtask

    task automatic test_descriptor();
        int e0;
        logic [31:0] d;
        e0 = errors;
        wb_write(32'h8000_0124, 4'hf, 32'h0bad_f00d);
        check_tf("trans_o", expected_tf(32'h8000_0124, 1'b1), last_tf);
        wb_read(32'h0000_0a6c, d);
        check_tf("trans_o", expected_tf(32'h0000_0a6c, 1'b0), last_tf);
        report("descriptor", e0);
    endtask

    task automatic test_chip_select();
        int e0;
        logic [31:0] d;
        e0 = errors;
        wb_read(32'h0000_2200, d);
        check_cs("trans_cs_o", 2'b01, last_cs);
        wb_read(32'h0000_5000, d);
        check_cs("trans_cs_o", 2'b10, last_cs);
        // overlap of both ranges
        wb_read(32'h0000_3200, d);
        check_cs("trans_cs_o", 2'b01, last_cs);
        wb_read(32'h0000_8000, d);
        check_cs("trans_cs_o", 2'b01, last_cs);
        report("chip_select", e0);
    endtask

    task automatic test_errors();
        int e0;
        logic [31:0] d;
        e0 = errors;
        wb_write(32'h0000_0500, 4'hf, 32'h5555_aaaa);
        @(posedge clk) err_rx <= 1'b1;
        wb_access(1'b0, 32'h0000_0500, 4'h0, 32'h0, 1'b1, d);
        check_word("dat_o", 32'h5555_aaaa, d);
        @(posedge clk) err_rx <= 1'b0;
        wb_read(32'h0000_0500, d);
        @(posedge clk) err_b <= 1'b1;
        wb_access(1'b1, 32'h0000_0500, 4'hf, 32'h1234_5678, 1'b1, d);
        @(posedge clk) err_b <= 1'b0;
        wb_write(32'h0000_0500, 4'hf, 32'h8765_4321);
        report("errors", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int k;
        logic [31:0] d;
        e0 = errors;
        @(posedge clk) stall_en <= 1'b1;
        for (int i = 0; i < 16; i++) begin
            rnd = lcg_step(rnd);
            ref_mem[i] = rnd;
            wb_write(32'h0000_0400 + 32'(i * 4), 4'hf, rnd);
        end
        for (int n = 0; n < 50; n++) begin
            rnd = lcg_step(rnd);
            k = int'(rnd[11:8]);
            if (rnd[31]) begin
                ref_mem[k] = lcg_step(rnd);
                wb_write(32'h0000_0400 + 32'(k * 4), 4'hf, ref_mem[k]);
            end else begin
                wb_read(32'h0000_0400 + 32'(k * 4), d);
                check_word("dat_o", ref_mem[k], d);
            end
        end
        @(posedge clk) stall_en <= 1'b0;
        report("backpressure", e0);
    endtask

    initial begin
        arst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        sel = '0;
        wdat = '0;
        stall_en = 1'b0;
        err_rx = 1'b0;
        err_b = 1'b0;
        // word address ranges, rule 0 overlaps the start of rule 1
        rules[0] = '{idx: 1'b0, start_addr: 31'h1000, end_addr: 31'h2000};
        rules[1] = '{idx: 1'b1, start_addr: 31'h1800, end_addr: 31'h3000};
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        test_reset_state();
        test_write_read();
        test_byte_lanes();
        test_descriptor();
        test_chip_select();
        test_errors();
        test_backpressure();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
